//--- audio_player.f
audio_pkg.sv
vmem_pkg.sv
audio_channel.sv
audio_fetch.sv
audio_mix.sv
audio_pdm.sv
audio_player.sv
audio_player_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it, passing only on the pass message
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module audio_player_tb \
    -f audio_player.f -o audio_player_sim &&
./obj_dir/audio_player_sim | tee /dev/stderr | grep -q "Finished with no errors" &&
exit 0 || exit 1

//--- audio_player_tb.sv
// audio player testbench: memory responder, reference DAC codes, fetch and density checks
`default_nettype none
`timescale 1ns/100ps

module audio_player_tb
    import audio_pkg::*, vmem_pkg::*;
();

localparam int DAC_W      = 8;
localparam int CLK_PERIOD = 8;
localparam int P_FAST     = 600;
localparam int P_SLOW     = 20;
localparam int SLOW_DELAY = 60;             // longer than two slow sample periods
localparam int WORD_CYC   = 2 * (P_FAST + 1);
localparam int TIMEOUT_CYCLES = 10 + 24 * WORD_CYC + 14 * (2 * (P_SLOW + 1) + SLOW_DELAY + 20)
                              + 2000 + 5000;

logic    clk = 1'b0;
logic    reset_i;
logic    enable_i;
logic    restart_i;
period_t period_i;
vaddr_t  start_i;
length_t len_i;
volume_t vol_l_i;
volume_t vol_r_i;
logic    reload_o;
logic    fetch_o;
vaddr_t  addr_o;
logic    ack_i = 1'b0;
vword_t  word_i = '0;
logic    pdm_l_o;
logic    pdm_r_o;

vword_t      mem [0:65535];
logic [31:0] lfsr = 32'h369e_9b6d;
logic        slow_mem;
logic        track;             // address checking armed
logic        quiet;             // no new fetch allowed
int          err_addr = 0;
int          err_count = 0;
int          err_other = 0;

audio_player #(
    .DAC_W (DAC_W)
) u_audio_player (
    .clk       (clk),
    .reset_i   (reset_i),
    .enable_i  (enable_i),
    .restart_i (restart_i),
    .period_i  (period_i),
    .start_i   (start_i),
    .len_i     (len_i),
    .vol_l_i   (vol_l_i),
    .vol_r_i   (vol_r_i),
    .reload_o  (reload_o),
    .fetch_o   (fetch_o),
    .addr_o    (addr_o),
    .ack_i     (ack_i),
    .word_i    (word_i),
    .pdm_l_o   (pdm_l_o),
    .pdm_r_o   (pdm_r_o)
);

always #(CLK_PERIOD / 2) clk = ~clk;

function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32 22 2 1
endfunction

task automatic draw_bits(input int n, output logic [31:0] v);
    int i;
    v = '0;
    for (i = 0; i < n; i++) begin
        lfsr = lfsr_next(lfsr);
        v    = {v[30:0], lfsr[0]};
    end
endtask

// expected DAC code: multiply, floor divide by 64, saturate, offset by mid-scale
function automatic logic [DAC_W-1:0] expected_code(input sample_t s, input volume_t v);
    integer p;
    integer q;
    integer lim;
    p   = integer'(s) * integer'(v);
    q   = p / 64;
    lim = 2 ** (DAC_W - 1);
    if (p < 0 && (p % 64) != 0) begin
        q = q - 1;
    end
    if (q > lim - 1) begin
        q = lim - 1;
    end else if (q < -lim) begin
        q = -lim;
    end
    return DAC_W'(q + lim);
endfunction

task automatic check_addr(input string name, input vaddr_t exp, input vaddr_t act);
    if (exp !== act) begin
        err_addr++;
        $display("** Error %s: expected %h, got %h at %0t", name, exp, act, $time);
    end
endtask

task automatic check_count(input string name, input integer exp, input integer act);
    if (exp !== act) begin
        err_count++;
        $display("** Error %s: expected %h, got %h at %0t", name, exp, act, $time);
    end
endtask

task automatic protocol_error(input string what);
    err_other++;
    $display("protocol failure at %0t: %s", $time, what);
endtask

task automatic print_error_counts();
    $display("errors: addr %0d, count %0d, other %0d",
             err_addr, err_count, err_other);
endtask

// memory responder, random 0 to 5 cycle latency plus an optional long one
int wait_cnt = 0;
logic busy = 1'b0;
always @(posedge clk) begin
    logic [31:0] r;
    if (reset_i) begin
        ack_i <= 1'b0;
        busy = 1'b0;
    end else if (ack_i) begin
        ack_i <= 1'b0;              // DUT takes the word on this edge
        busy = 1'b0;
    end else if (fetch_o) begin
        if (!busy) begin
            busy = 1'b1;
            draw_bits(3, r);
            wait_cnt = int'(r[2:0]) % 6;
            if (slow_mem) begin
                wait_cnt = wait_cnt + SLOW_DELAY;
            end
        end
        if (wait_cnt == 0) begin
            ack_i  <= 1'b1;
            word_i <= mem[addr_o];
        end else begin
            wait_cnt = wait_cnt - 1;
        end
    end
end

// handshake rules, sampled between edges
logic   hs_fetch = 1'b0;
logic   hs_ack = 1'b0;
vaddr_t hs_addr = '0;
always @(negedge clk) begin
    if (reset_i) begin
        if (fetch_o) begin
            protocol_error("fetch_o is high during reset");
        end
        hs_fetch = 1'b0;
    end else begin
        if (hs_fetch && !hs_ack) begin
            if (!fetch_o) begin
                protocol_error("fetch_o fell before ack_i");
            end else begin
                check_addr("addr_o held", hs_addr, addr_o);
            end
        end
        if (hs_fetch && hs_ack && fetch_o) begin
            protocol_error("fetch_o still high in the cycle after ack_i");
        end
        hs_fetch = fetch_o;
        hs_ack   = ack_i;
        hs_addr  = addr_o;
    end
end

// address order and reload pulses
logic   fetch_d = 1'b0;
vaddr_t exp_addr = '0;
int     reload_cnt = 0;
int     wrap_cnt = 0;
always @(posedge clk) begin
    if (!track) begin
        exp_addr   = start_i;
        reload_cnt = 0;
        wrap_cnt   = 0;
    end else begin
        if (reload_o) begin
            reload_cnt++;
        end
        if (fetch_o && !fetch_d) begin
            check_addr("addr_o", exp_addr, addr_o);
            if (exp_addr == start_i) begin
                wrap_cnt++;
                check_count("reload_o pulses", wrap_cnt, reload_cnt);
            end
            exp_addr = (exp_addr == start_i + vaddr_t'(len_i)) ? start_i : exp_addr + 16'd1;
        end
    end
    if (quiet && fetch_o && !fetch_d) begin
        protocol_error("fetch_o rose while the channel was disabled");
    end
    fetch_d = fetch_o;
end

task automatic skip(input int n);
    repeat (n) @(negedge clk);
endtask

task automatic wait_fetch_rise(output vaddr_t a);
    logic was;
    @(negedge clk);
    was = fetch_o;
    @(negedge clk);
    while (!(fetch_o && !was)) begin
        was = fetch_o;
        @(negedge clk);
    end
    a = addr_o;
endtask

task automatic count_pulses(input int n, output int cl, output int cr);
    cl = 0;
    cr = 0;
    repeat (n) begin
        @(negedge clk);
        cl = cl + int'(pdm_l_o);
        cr = cr + int'(pdm_r_o);
    end
endtask

// low byte of a0 goes out one cycle before the rise for a1, high byte of a1 one period later
task automatic measure_pair(input vaddr_t a0, input vaddr_t a1);
    int      cl;
    int      cr;
    sample_t s;
    skip(6);
    count_pulses(2 ** DAC_W, cl, cr);
    s = sample_t'(mem[a0][7:0]);
    check_count("pdm_l_o density", int'(expected_code(s, vol_l_i)), cl);
    check_count("pdm_r_o density", int'(expected_code(s, vol_r_i)), cr);
    skip(P_FAST - 250);
    count_pulses(2 ** DAC_W, cl, cr);
    s = sample_t'(mem[a1][15:8]);
    check_count("pdm_l_o density", int'(expected_code(s, vol_l_i)), cl);
    check_count("pdm_r_o density", int'(expected_code(s, vol_r_i)), cr);
endtask

initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("timeout: the run did not finish in %0d cycles", TIMEOUT_CYCLES);
    print_error_counts();
    $display("Finished with errors");
    $finish;
end

initial begin
    logic [31:0] r;
    vaddr_t      a0;
    vaddr_t      a1;
    int          cl;
    int          cr;
    int          k;
    time         t_prev;
    time         t_now;
    reset_i   = 1'b1;
    enable_i  = 1'b0;
    restart_i = 1'b0;
    period_i  = period_t'(P_FAST);
    start_i   = 16'h4a10;
    len_i     = 15'd3;
    vol_l_i   = 7'd64;
    vol_r_i   = 7'd64;
    slow_mem  = 1'b0;
    track     = 1'b0;
    quiet     = 1'b0;
    for (k = 0; k < 65536; k++) begin
        draw_bits(16, r);
        mem[k] = r[15:0];
    end
    mem[16'h4a10] = 16'h807f;       // full-scale bytes for saturation

    repeat (10) @(posedge clk);
    reset_i <= 1'b0;
    @(posedge clk);
    enable_i  <= 1'b1;
    restart_i <= 1'b1;
    track     <= 1'b1;
    @(posedge clk);
    restart_i <= 1'b0;

    // densities at several volume pairs, four words per pair
    wait_fetch_rise(a0);
    t_prev = $time;
    for (k = 0; k < 16; k++) begin
        wait_fetch_rise(a1);
        t_now = $time;
        // two samples per word, each held period_i+1 cycles
        check_count("fetch_o rise spacing", 2 * (P_FAST + 1),
                    int'((t_now - t_prev) / CLK_PERIOD));
        t_prev = t_now;
        measure_pair(a0, a1);
        a0 = a1;
        @(posedge clk);
        case (k)
            3: begin
                vol_l_i <= 7'd127;
                vol_r_i <= 7'd127;
            end
            7: begin
                vol_l_i <= 7'd100;
                vol_r_i <= 7'd127;
            end
            11: begin
                vol_l_i <= 7'd32;
                vol_r_i <= 7'd0;
            end
            default: ;
        endcase
    end

    // disable, outputs go to mid-scale and fetches stop
    @(posedge clk);
    enable_i <= 1'b0;
    track    <= 1'b0;
    skip(4);
    while (fetch_o) begin
        @(negedge clk);
    end
    @(posedge clk);
    quiet <= 1'b1;
    skip(20);
    count_pulses(2 ** DAC_W, cl, cr);
    check_count("pdm_l_o density disabled", 2 ** (DAC_W - 1), cl);
    check_count("pdm_r_o density disabled", 2 ** (DAC_W - 1), cr);
    @(posedge clk);
    quiet    <= 1'b0;
    enable_i <= 1'b1;
    track    <= 1'b1;

    // slow memory against a short period
    wait_fetch_rise(a0);
    @(posedge clk);
    slow_mem <= 1'b1;
    period_i <= period_t'(P_SLOW);
    for (k = 0; k < 12; k++) begin
        wait_fetch_rise(a0);
    end
    @(posedge clk);
    slow_mem <= 1'b0;
    period_i <= period_t'(P_FAST);
    vol_l_i  <= 7'd127;
    vol_r_i  <= 7'd48;
    wait_fetch_rise(a0);
    wait_fetch_rise(a0);
    wait_fetch_rise(a0);
    for (k = 0; k < 4; k++) begin
        wait_fetch_rise(a1);
        measure_pair(a0, a1);
        a0 = a1;
    end

    print_error_counts();
    if (err_addr + err_count + err_other == 0) begin
        $display("Finished with no errors");
    end else begin
        $display("Finished with errors");
    end
    $finish;
end

endmodule

`default_nettype wire

//--- audio_player.sv
// audio player top: sequencer, fetch, mixer and two PDM DACs for one sample channel
`default_nettype none
`timescale 1ns/100ps

module audio_player
    import audio_pkg::*, vmem_pkg::*;
#(
    parameter int DAC_W = 8
)(
    input  wire logic    clk,
    input  wire logic    reset_i,
    input  wire logic    enable_i,
    input  wire logic    restart_i,
    input  wire period_t period_i,
    input  wire vaddr_t  start_i,
    input  wire length_t len_i,
    input  wire volume_t vol_l_i,
    input  wire volume_t vol_r_i,
    output logic         reload_o,
    output logic         fetch_o,
    output vaddr_t       addr_o,
    input  wire logic    ack_i,
    input  wire vword_t  word_i,
    output logic         pdm_l_o,
    output logic         pdm_r_o
);

logic             fetch_need;
vaddr_t           fetch_addr;
logic             word_valid;
vword_t           word_data;
sample_t          sample_val;
logic [DAC_W-1:0] code_l;
logic [DAC_W-1:0] code_r;

audio_channel u_channel (
    .clk          (clk),
    .reset_i      (reset_i),
    .enable_i     (enable_i),
    .restart_i    (restart_i),
    .period_i     (period_i),
    .start_i      (start_i),
    .len_i        (len_i),
    .word_valid_i (word_valid),
    .word_i       (word_data),
    .fetch_need_o (fetch_need),
    .fetch_addr_o (fetch_addr),
    .sample_o     (sample_val),
    .reload_o     (reload_o)
);

audio_fetch u_fetch (
    .clk          (clk),
    .reset_i      (reset_i),
    .need_i       (fetch_need),
    .addr_i       (fetch_addr),
    .fetch_o      (fetch_o),
    .addr_o       (addr_o),
    .ack_i        (ack_i),
    .word_i       (word_i),
    .word_valid_o (word_valid),
    .word_o       (word_data)
);

audio_mix #(
    .DAC_W (DAC_W)
) u_mix (
    .clk      (clk),
    .reset_i  (reset_i),
    .sample_i (sample_val),
    .vol_l_i  (vol_l_i),
    .vol_r_i  (vol_r_i),
    .code_l_o (code_l),
    .code_r_o (code_r)
);

// left and right DACs
audio_pdm #(
    .DAC_W (DAC_W)
) u_pdm_l (
    .clk     (clk),
    .reset_i (reset_i),
    .code_i  (code_l),
    .pulse_o (pdm_l_o)
);

audio_pdm #(
    .DAC_W (DAC_W)
) u_pdm_r (
    .clk     (clk),
    .reset_i (reset_i),
    .code_i  (code_r),
    .pulse_o (pdm_r_o)
);

endmodule

`default_nettype wire

//--- audio_pdm.sv
// first-order pulse-density modulator: carry out of a code accumulator drives a 1-bit output
`default_nettype none
`timescale 1ns/100ps

module audio_pdm #(
    parameter int DAC_W = 8
)(
    input  wire logic              clk,
    input  wire logic              reset_i,
    input  wire logic [DAC_W-1:0]  code_i,
    output logic                   pulse_o
);

logic [DAC_W-1:0] acc_q;
logic [DAC_W:0]   sum;          // top bit is the carry

assign sum = {1'b0, acc_q} + {1'b0, code_i};

always_ff @(posedge clk) begin
    if (reset_i) begin
        acc_q   <= '0;
        pulse_o <= 1'b0;
    end else begin
        acc_q   <= sum[DAC_W-1:0];  // wraps, so code_i carries per 2^DAC_W cycles
        pulse_o <= sum[DAC_W];
    end
end

endmodule

`default_nettype wire

//--- audio_mix.sv
// audio mixer: scales a sample by left and right volume and saturates to unsigned DAC codes
`default_nettype none
`timescale 1ns/100ps

module audio_mix
    import audio_pkg::*;
#(
    parameter int DAC_W = 8
)(
    input  wire logic          clk,
    input  wire logic          reset_i,
    input  wire sample_t       sample_i,
    input  wire volume_t       vol_l_i,
    input  wire volume_t       vol_r_i,
    output logic [DAC_W-1:0]   code_l_o,
    output logic [DAC_W-1:0]   code_r_o
);

localparam int CODE_MAX = 2**(DAC_W-1) - 1;
localparam int CODE_MIN = -(2**(DAC_W-1));
localparam logic [DAC_W-1:0] CODE_MID = {1'b1, {(DAC_W-1){1'b0}}};

logic signed [7:0]  vol_l_s;    // volumes as positive signed values
logic signed [7:0]  vol_r_s;
logic signed [15:0] prod_l;
logic signed [15:0] prod_r;

// divide by unity gain, clip to the signed code range, then flip to offset binary
function automatic logic [DAC_W-1:0] to_code(input logic signed [15:0] prod);
    logic signed [15:0] scaled;
    logic [DAC_W-1:0]   code;
    scaled = prod >>> VOL_SHIFT;        // rounds toward minus infinity
    if (scaled > CODE_MAX) begin
        code = '1;
    end else if (scaled < CODE_MIN) begin
        code = '0;
    end else begin
        code = {~scaled[DAC_W-1], scaled[DAC_W-2:0]};
    end
    return code;
endfunction

assign vol_l_s = {1'b0, vol_l_i};
assign vol_r_s = {1'b0, vol_r_i};

// stage one, products
always_ff @(posedge clk) begin
    prod_l <= sample_i * vol_l_s;
    prod_r <= sample_i * vol_r_s;
end

// stage two, registered codes
always_ff @(posedge clk) begin
    if (reset_i) begin
        code_l_o <= CODE_MID;
        code_r_o <= CODE_MID;
    end else begin
        code_l_o <= to_code(prod_l);
        code_r_o <= to_code(prod_r);
    end
end

endmodule

`default_nettype wire

//--- audio_fetch.sv
// audio fetch stage: turns a word request into a memory read with request and acknowledge
`default_nettype none
`timescale 1ns/100ps

module audio_fetch
    import audio_pkg::*, vmem_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   reset_i,
    input  wire logic   need_i,
    input  wire vaddr_t addr_i,
    output logic        fetch_o,
    output vaddr_t      addr_o,
    input  wire logic   ack_i,
    input  wire vword_t word_i,
    output logic        word_valid_o,
    output vword_t      word_o
);

fetch_st_t state_q;
fetch_st_t state_d;

always_comb begin
    state_d = state_q;
    case (state_q)
        FETCH_IDLE: begin
            if (need_i) begin
                state_d = FETCH_WAIT;
            end
        end
        FETCH_WAIT: begin
            if (ack_i) begin
                state_d = FETCH_IDLE;   // memory may take any number of cycles
            end
        end
        default: begin
            state_d = FETCH_IDLE;
        end
    endcase
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        state_q <= FETCH_IDLE;
    end else begin
        state_q <= state_d;
    end
end

// address is captured once and held for the whole request
always_ff @(posedge clk) begin
    if (state_q == FETCH_IDLE && need_i) begin
        addr_o <= addr_i;
    end
end

assign fetch_o      = (state_q == FETCH_WAIT);
assign word_valid_o = (state_q == FETCH_WAIT) && ack_i;    // data is valid with the ack
assign word_o       = word_i;

endmodule

`default_nettype wire

//--- audio_channel.sv
// audio channel sequencer: paces samples, walks the sample block and asks for packed words
`default_nettype none
`timescale 1ns/100ps

module audio_channel
    import audio_pkg::*, vmem_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    reset_i,
    input  wire logic    enable_i,
    input  wire logic    restart_i,
    input  wire period_t period_i,
    input  wire vaddr_t  start_i,
    input  wire length_t len_i,
    input  wire logic    word_valid_i,
    input  wire vword_t  word_i,
    output logic         fetch_need_o,
    output vaddr_t       fetch_addr_o,
    output sample_t      sample_o,
    output logic         reload_o
);

logic [15:0] period_cnt;        // bit 15 set means the period expired
vaddr_t      addr_q;            // word to fetch next
length_t     len_q;             // words left after addr_q
vword_t      buf_q;             // sample buffer, next byte out sits in [15:8]
logic [1:0]  buf_ok;            // valid flags, shifted along with the bytes
logic        need_q;            // word wanted and not yet delivered
logic        restart_pend;      // block parameters must be reloaded
sample_t     sample_q;

logic        step;              // sample tick
logic        word_end;          // last byte of the word goes out on this tick
logic        restart_load;
logic        block_load;

assign step     = period_cnt[15] && enable_i;
assign word_end = step && (buf_ok == 2'b10);

// a word still in flight from before the restart is let through and dropped first
assign restart_load = restart_pend && !need_q && enable_i && !restart_i;
assign block_load   = restart_load || (word_end && (len_q == '0));

always_ff @(posedge clk) begin
    if (reset_i) begin
        period_cnt   <= '1;
        addr_q       <= '0;
        len_q        <= '0;
        buf_ok       <= 2'b00;
        need_q       <= 1'b0;
        restart_pend <= 1'b1;
        sample_q     <= '0;
        reload_o     <= 1'b0;
    end else begin
        reload_o   <= 1'b0;
        period_cnt <= period_cnt - 1'b1;

        if (step) begin
            period_cnt <= {1'b0, period_i} - 1'b1;  // next tick period_i+1 cycles on
            // with an empty buffer the last sample simply stays
            if (buf_ok[1]) begin
                sample_q    <= buf_q[15:8];
                buf_q[15:8] <= buf_q[7:0];
                buf_ok      <= {buf_ok[0], 1'b0};
            end
        end

        if (block_load) begin
            addr_q   <= start_i;    // back to the top of the block
            len_q    <= len_i;
            reload_o <= 1'b1;
        end else if (word_end) begin
            addr_q <= addr_q + 1'b1;
            len_q  <= len_q - 1'b1;
        end

        if (word_end || restart_load) begin
            need_q <= 1'b1;         // buffer is empty from here on
        end
        if (restart_load) begin
            restart_pend <= 1'b0;
        end

        if (word_valid_i) begin
            need_q <= 1'b0;
            if (!restart_pend) begin    // stale word otherwise
                buf_q  <= word_i;
                buf_ok <= 2'b11;
            end
        end

        if (restart_i || !enable_i) begin
            restart_pend   <= 1'b1;
            buf_ok         <= 2'b00;
            period_cnt[15] <= 1'b1; // first tick comes right away
        end
        if (!enable_i) begin
            sample_q <= '0;
        end
    end
end

assign fetch_need_o = need_q;
assign fetch_addr_o = addr_q;
assign sample_o     = enable_i ? sample_q : '0;     // silent while disabled

endmodule

`default_nettype wire

//--- vmem_pkg.sv
// video memory types seen by the audio fetch path: word address and packed data word
`default_nettype none

package vmem_pkg;

    // word address into video memory
    typedef logic [15:0] vaddr_t;

    // memory word, high byte is played first
    typedef logic [15:0] vword_t;

endpackage

`default_nettype wire

//--- audio_pkg.sv
// audio types shared by the playback stages: samples, gains, timing counts and fetch states
`default_nettype none

package audio_pkg;

    // one signed 8-bit sample, two of them are packed per memory word
    typedef logic signed [7:0] sample_t;

    // channel volume, 64 is unity gain and 127 is almost double
    typedef logic [6:0] volume_t;

    // clocks per sample minus one
    typedef logic [14:0] period_t;

    // remaining words of a sample block minus one
    typedef logic [14:0] length_t;

    // shift that divides a sample times volume product back down by unity gain
    localparam int VOL_SHIFT = 6;

    // fetch stage states
    typedef enum logic {
        FETCH_IDLE = 1'b0,      // waiting for the sequencer to want a word
        FETCH_WAIT = 1'b1       // request out, waiting for memory ack
    } fetch_st_t;

endpackage

`default_nettype wire
